/* udp_rx_pkg.sv */
`default_nettype none

package udp_rx_pkg;

  // Stream and field widths
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] port_t;
  typedef logic [15:0] len_t;        // Lengths and byte counts
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [7:0]  proto_t;

  localparam int     UDP_HDR_LEN = 8;     // Bytes
  localparam proto_t PROTO_UDP   = 8'd17;

  // Field order as on the wire, first byte in the MSBs
  typedef struct packed {
    port_t       src_port;
    port_t       dst_port;
    len_t        length;     // Header plus payload
    logic [15:0] cks;
  } udp_hdr_t;

endpackage

`default_nettype wire

/* ipv4_rx_if.sv */
`default_nettype none

interface ipv4_rx_if;
  import udp_rx_pkg::*;

  byte_t      dat;
  logic       val;
  logic       sof;
  logic       eof;
  logic       err;

  // Stable from sof to eof
  proto_t     proto;
  ipv4_addr_t src_ip;
  ipv4_addr_t dst_ip;
  len_t       pld_len;     // IPv4 payload length

  modport ipv4_src (
    output dat, val, sof, eof, err,
    output proto, src_ip, dst_ip, pld_len
  );

  modport ipv4_snk (
    input dat, val, sof, eof, err,
    input proto, src_ip, dst_ip, pld_len
  );

endinterface

`default_nettype wire

/* udp_rx_if.sv */
`default_nettype none

interface udp_rx_if;
  import udp_rx_pkg::*;

  byte_t      dat;
  logic       val;
  logic       sof;   // First payload byte
  logic       eof;   // Last payload byte
  logic       err;   // Pulses with eof

  // Latched header, valid from sof
  udp_hdr_t   hdr;
  ipv4_addr_t src_ip;

  modport udp_src (
    output dat, val, sof, eof, err,
    output hdr, src_ip
  );

  modport udp_snk (
    input dat, val, sof, eof, err,
    input hdr, src_ip
  );

endinterface

`default_nettype wire

/* udp_hdr_rx.sv */
`default_nettype none

module udp_hdr_rx (
  input logic          clk,
  input logic          fsm_rst,
  ipv4_rx_if.ipv4_snk  ipv4,
  udp_rx_if.udp_src    udp
);
  import udp_rx_pkg::*;

  logic receiving;
  logic frame_clr;    // High in the cycle of the output eof
  logic err_seen;     // Input err seen earlier in this packet
  len_t byte_cnt;
  len_t cur_idx;

  logic is_udp;
  logic active;
  logic hdr_byte;
  logic hdr_last;
  logic pld_byte;
  logic len_err;
  logic err_acc;

  // Header bytes 0..6, byte 7 joins straight from the input
  byte_t [UDP_HDR_LEN-2:0] hdr_sr;

  assign is_udp  = (ipv4.proto == PROTO_UDP);
  assign cur_idx = ipv4.sof ? '0 : byte_cnt;    // Index of the byte on the input now

  // A new packet may start in the same cycle the old one is cleared
  assign active = ipv4.val && is_udp && (ipv4.sof || (receiving && !frame_clr));

  assign hdr_byte = active && (cur_idx < len_t'(UDP_HDR_LEN - 1));
  assign hdr_last = active && (cur_idx == len_t'(UDP_HDR_LEN - 1));
  assign pld_byte = active && (cur_idx >= len_t'(UDP_HDR_LEN));

  // Byte count so far, header included, against the IPv4 payload length
  assign len_err = (len_t'(cur_idx + len_t'(1)) != ipv4.pld_len);
  assign err_acc = (err_seen && !ipv4.sof) || ipv4.err;

  // Frame state
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      receiving <= 1'b0;
      frame_clr <= 1'b0;
      err_seen  <= 1'b0;
      byte_cnt  <= '0;
    end else begin
      frame_clr <= active && ipv4.eof;
      if (frame_clr) begin
        receiving <= 1'b0;
        err_seen  <= 1'b0;
        byte_cnt  <= '0;
      end
      if (active) begin
        receiving <= 1'b1;
        err_seen  <= err_acc;
        byte_cnt  <= len_t'(cur_idx + len_t'(1));
      end else if (ipv4.val && ipv4.sof) begin
        receiving <= 1'b0;    // Other protocol, drop any open frame
      end
    end
  end

  // Header shift and latch
  always_ff @(posedge clk) begin
    if (hdr_byte) begin
      hdr_sr <= {hdr_sr[UDP_HDR_LEN-3:0], ipv4.dat};
    end
    if (hdr_last) begin
      udp.hdr    <= udp_hdr_t'({hdr_sr, ipv4.dat});
      udp.src_ip <= ipv4.src_ip;
    end
  end

  always_ff @(posedge clk) begin
    udp.dat <= ipv4.dat;
  end

  // Output strobes, one cycle behind the input
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      udp.val <= 1'b0;
      udp.sof <= 1'b0;
      udp.eof <= 1'b0;
      udp.err <= 1'b0;
    end else begin
      udp.val <= pld_byte;
      udp.sof <= pld_byte && (cur_idx == len_t'(UDP_HDR_LEN));
      udp.eof <= pld_byte && ipv4.eof;
      udp.err <= pld_byte && ipv4.eof && (len_err || err_acc);
    end
  end

endmodule

`default_nettype wire

/* udp_port_filter.sv */
`default_nettype none

module udp_port_filter #(
  parameter udp_rx_pkg::port_t LOCAL_PORT = 16'h1234
) (
  input  logic              clk,
  input  logic              fsm_rst,
  udp_rx_if.udp_snk         udp_in,
  udp_rx_if.udp_src         udp_out,
  output udp_rx_pkg::len_t  rx_cnt,
  output udp_rx_pkg::len_t  drop_cnt
);
  import udp_rx_pkg::*;

  logic start;
  logic match;
  logic pass_q;      // Decision for the datagram in flight
  logic pass_now;

  assign start    = udp_in.val && udp_in.sof;
  assign match    = (udp_in.hdr.dst_port == LOCAL_PORT);
  assign pass_now = start ? match : pass_q;

  // Decision is taken at sof and held until eof
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pass_q <= 1'b0;
    end else if (udp_in.val) begin
      pass_q <= pass_now && !udp_in.eof;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rx_cnt   <= '0;
      drop_cnt <= '0;
    end else if (start) begin
      if (match) begin
        rx_cnt <= rx_cnt + len_t'(1);
      end else begin
        drop_cnt <= drop_cnt + len_t'(1);
      end
    end
  end

  // Header once per accepted datagram
  always_ff @(posedge clk) begin
    if (start && match) begin
      udp_out.hdr    <= udp_in.hdr;
      udp_out.src_ip <= udp_in.src_ip;
    end
  end

  always_ff @(posedge clk) begin
    udp_out.dat <= udp_in.dat;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      udp_out.val <= 1'b0;
      udp_out.sof <= 1'b0;
      udp_out.eof <= 1'b0;
      udp_out.err <= 1'b0;
    end else begin
      udp_out.val <= udp_in.val && pass_now;
      udp_out.sof <= start && match;
      udp_out.eof <= udp_in.val && udp_in.eof && pass_now;
      udp_out.err <= udp_in.val && udp_in.err && pass_now;
    end
  end

endmodule

`default_nettype wire

/* udp_rx_top.sv */
`default_nettype none

module udp_rx_top #(
  parameter udp_rx_pkg::port_t LOCAL_PORT = 16'h1234
) (
  input  logic                    clk,
  input  logic                    fsm_rst,

  // IPv4 payload stream and metadata
  input  udp_rx_pkg::byte_t       in_dat,
  input  logic                    in_val,
  input  logic                    in_sof,
  input  logic                    in_eof,
  input  logic                    in_err,
  input  udp_rx_pkg::proto_t      in_proto,
  input  udp_rx_pkg::ipv4_addr_t  in_src_ip,
  input  udp_rx_pkg::ipv4_addr_t  in_dst_ip,
  input  udp_rx_pkg::len_t        in_pld_len,

  // UDP payload stream and header
  output udp_rx_pkg::byte_t       out_dat,
  output logic                    out_val,
  output logic                    out_sof,
  output logic                    out_eof,
  output logic                    out_err,
  output udp_rx_pkg::port_t       out_src_port,
  output udp_rx_pkg::port_t       out_dst_port,
  output udp_rx_pkg::len_t        out_length,
  output logic [15:0]             out_cks,
  output udp_rx_pkg::ipv4_addr_t  out_src_ip,
  output udp_rx_pkg::len_t        rx_cnt,
  output udp_rx_pkg::len_t        drop_cnt
);

  ipv4_rx_if ipv4_bus ();
  udp_rx_if  udp_hdr_bus ();   // Parser to filter
  udp_rx_if  udp_flt_bus ();   // Filter to outputs

  assign ipv4_bus.dat     = in_dat;
  assign ipv4_bus.val     = in_val;
  assign ipv4_bus.sof     = in_sof;
  assign ipv4_bus.eof     = in_eof;
  assign ipv4_bus.err     = in_err;
  assign ipv4_bus.proto   = in_proto;
  assign ipv4_bus.src_ip  = in_src_ip;
  assign ipv4_bus.dst_ip  = in_dst_ip;
  assign ipv4_bus.pld_len = in_pld_len;

  udp_hdr_rx i_hdr_rx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .ipv4    (ipv4_bus.ipv4_snk),
    .udp     (udp_hdr_bus.udp_src)
  );

  udp_port_filter #(
    .LOCAL_PORT (LOCAL_PORT)
  ) i_port_filter (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .udp_in   (udp_hdr_bus.udp_snk),
    .udp_out  (udp_flt_bus.udp_src),
    .rx_cnt   (rx_cnt),
    .drop_cnt (drop_cnt)
  );

  assign out_dat      = udp_flt_bus.dat;
  assign out_val      = udp_flt_bus.val;
  assign out_sof      = udp_flt_bus.sof;
  assign out_eof      = udp_flt_bus.eof;
  assign out_err      = udp_flt_bus.err;
  assign out_src_port = udp_flt_bus.hdr.src_port;
  assign out_dst_port = udp_flt_bus.hdr.dst_port;
  assign out_length   = udp_flt_bus.hdr.length;
  assign out_cks      = udp_flt_bus.hdr.cks;
  assign out_src_ip   = udp_flt_bus.src_ip;

endmodule

`default_nettype wire

/* tb_udp_rx_checker.sv */
`default_nettype none

module tb_udp_rx_checker (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  udp_rx_pkg::byte_t       out_dat,
  input  logic                    out_val,
  input  logic                    out_sof,
  input  logic                    out_eof,
  input  logic                    out_err,
  input  udp_rx_pkg::port_t       out_src_port,
  input  udp_rx_pkg::port_t       out_dst_port,
  input  udp_rx_pkg::len_t        out_length,
  input  logic [15:0]             out_cks,
  input  udp_rx_pkg::ipv4_addr_t  out_src_ip,
  input  udp_rx_pkg::len_t        rx_cnt,
  input  udp_rx_pkg::len_t        drop_cnt,
  output logic                    busy,       // Datagrams still owed by the DUT
  output int                      err_cnt,
  output int                      check_cnt
);
  import udp_rx_pkg::*;

  udp_hdr_t   exp_hdr_q[$];
  ipv4_addr_t exp_ip_q[$];
  logic       exp_err_q[$];
  int         exp_n_q[$];
  byte_t      exp_byte_q[$];

  udp_hdr_t   cur_hdr;
  logic       cur_err;
  int         cur_n;
  int         byte_idx;
  logic       in_frame;
  logic       skip_frame;   // Unexpected datagram
  logic       rst_seen;

  initial begin
    busy       = 1'b0;
    err_cnt    = 0;
    check_cnt  = 0;
    in_frame   = 1'b0;
    skip_frame = 1'b0;
    rst_seen   = 1'b0;
  end

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic add_record(input port_t sp, input port_t dp, input len_t ln,
                            input logic [15:0] ck, input ipv4_addr_t ip,
                            input logic err, input int n);
    udp_hdr_t hdr;
    hdr = {sp, dp, ln, ck};
    exp_hdr_q.push_back(hdr);
    exp_ip_q.push_back(ip);
    exp_err_q.push_back(err);
    exp_n_q.push_back(n);
    busy = 1'b1;
  endtask

  task automatic add_byte(input byte_t b);
    exp_byte_q.push_back(b);
  endtask

  // Discard expected bytes the DUT never delivered
  task automatic drop_rest();
    byte_t junk;
    while (byte_idx < cur_n) begin
      junk = exp_byte_q.pop_front();
      byte_idx++;
    end
  endtask

  task automatic start_frame();
    if (in_frame) begin
      err_cnt++;
      $display("New datagram at %0t before the previous one ended", $time);
      drop_rest();
    end
    if (exp_n_q.size() == 0) begin
      err_cnt++;
      $display("Unexpected datagram at %0t with no expected record left", $time);
      in_frame   = 1'b0;
      skip_frame = 1'b1;
    end else begin
      cur_hdr = exp_hdr_q.pop_front();
      cur_err = exp_err_q.pop_front();
      cur_n   = exp_n_q.pop_front();
      compare("out_src_port", cur_hdr.src_port, out_src_port);
      compare("out_dst_port", cur_hdr.dst_port, out_dst_port);
      compare("out_length", cur_hdr.length, out_length);
      compare("out_cks", cur_hdr.cks, out_cks);
      compare("out_src_ip", exp_ip_q.pop_front(), out_src_ip);
      byte_idx   = 0;
      in_frame   = 1'b1;
      skip_frame = 1'b0;
    end
  endtask

  task automatic take_byte();
    if (out_sof) start_frame();
    if (in_frame) begin
      if (byte_idx < cur_n) compare("out_dat", exp_byte_q.pop_front(), out_dat);
      byte_idx++;
      if (out_eof) begin
        compare("payload byte count", cur_n, byte_idx);
        compare("out_err", cur_err, out_err);
        drop_rest();
        in_frame = 1'b0;
      end else begin
        compare("out_err", 1'b0, out_err);   // Only allowed with eof
      end
    end else if (!skip_frame) begin
      err_cnt++;
      $display("Payload byte at %0t outside any datagram", $time);
    end
    if (out_eof) skip_frame = 1'b0;
  endtask

  task automatic final_check(input len_t exp_rx, input len_t exp_drop);
    if (in_frame || exp_n_q.size() != 0) begin
      err_cnt++;
      $display("%0d expected datagram(s) did not come out in full",
               exp_n_q.size() + (in_frame ? 1 : 0));
    end
    compare("rx_cnt", exp_rx, rx_cnt);
    compare("drop_cnt", exp_drop, drop_cnt);
  endtask

  always @(posedge clk) begin
    if (fsm_rst) rst_seen <= 1'b1;
  end

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (fsm_rst) begin
      if (rst_seen) begin
        compare("out_val", 1'b0, out_val);
        compare("out_sof", 1'b0, out_sof);
        compare("out_eof", 1'b0, out_eof);
        compare("out_err", 1'b0, out_err);
        compare("rx_cnt", '0, rx_cnt);
        compare("drop_cnt", '0, drop_cnt);
      end
    end else if (out_val) begin
      take_byte();
    end else if (out_sof || out_eof || out_err) begin
      err_cnt++;
      $display("Frame strobe at %0t while out_val is low", $time);
    end
    busy = in_frame || (exp_n_q.size() != 0);
  end

endmodule

`default_nettype wire

/* tb_udp_rx.sv */
`default_nettype none

module tb_udp_rx;
  import udp_rx_pkg::*;

  logic        clk;
  logic        fsm_rst;
  byte_t       in_dat;
  logic        in_val;
  logic        in_sof;
  logic        in_eof;
  logic        in_err;
  proto_t      in_proto;
  ipv4_addr_t  in_src_ip;
  ipv4_addr_t  in_dst_ip;
  len_t        in_pld_len;

  byte_t       out_dat;
  logic        out_val;
  logic        out_sof;
  logic        out_eof;
  logic        out_err;
  port_t       out_src_port;
  port_t       out_dst_port;
  len_t        out_length;
  logic [15:0] out_cks;
  ipv4_addr_t  out_src_ip;
  len_t        rx_cnt;
  len_t        drop_cnt;

  logic        busy;
  int          err_cnt;
  int          check_cnt;

  // Packets read from the stimulus file
  proto_t      pkt_proto[$];
  ipv4_addr_t  pkt_ip[$];
  len_t        pkt_len[$];
  logic        pkt_err[$];
  int          pkt_gap[$];
  int          pkt_n[$];
  byte_t       pkt_bytes[$];

  len_t        exp_rx;
  len_t        exp_drop;
  int          stim_errs;
  int          cycle_limit;
  int          cycle_cnt;
  int          fd;
  int          p;
  int          base;
  int          waited;

  udp_rx_top #(
    .LOCAL_PORT (16'h1234)
  ) i_dut (
    .clk (clk), .fsm_rst (fsm_rst),
    .in_dat (in_dat), .in_val (in_val), .in_sof (in_sof), .in_eof (in_eof),
    .in_err (in_err), .in_proto (in_proto), .in_src_ip (in_src_ip),
    .in_dst_ip (in_dst_ip), .in_pld_len (in_pld_len),
    .out_dat (out_dat), .out_val (out_val), .out_sof (out_sof), .out_eof (out_eof),
    .out_err (out_err), .out_src_port (out_src_port), .out_dst_port (out_dst_port),
    .out_length (out_length), .out_cks (out_cks), .out_src_ip (out_src_ip),
    .rx_cnt (rx_cnt), .drop_cnt (drop_cnt)
  );

  tb_udp_rx_checker i_checker (
    .clk (clk), .fsm_rst (fsm_rst),
    .out_dat (out_dat), .out_val (out_val), .out_sof (out_sof), .out_eof (out_eof),
    .out_err (out_err), .out_src_port (out_src_port), .out_dst_port (out_dst_port),
    .out_length (out_length), .out_cks (out_cks), .out_src_ip (out_src_ip),
    .rx_cnt (rx_cnt), .drop_cnt (drop_cnt),
    .busy (busy), .err_cnt (err_cnt), .check_cnt (check_cnt)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic read_stim(input int fh);
    logic [63:0]        tok;
    logic [8*256-1:0]   rest;
    logic [31:0]        a, b, c, d, e;
    int                 f, g, n, i, rc;
    rc = $fscanf(fh, " %s", tok);
    while (rc == 1) begin
      if (tok == "#") begin
        rc = $fgets(rest, fh);
      end else if (tok == "P") begin
        rc = $fscanf(fh, " %h %h %h %d %d %d", a, b, c, f, g, n);
        pkt_proto.push_back(a[7:0]);
        pkt_ip.push_back(b);
        pkt_len.push_back(c[15:0]);
        pkt_err.push_back(f != 0);
        pkt_gap.push_back(g);
        pkt_n.push_back(n);
        for (i = 0; i < n; i++) begin
          rc = $fscanf(fh, " %h", a);
          pkt_bytes.push_back(a[7:0]);
        end
      end else if (tok == "E") begin
        rc = $fscanf(fh, " %h %h %h %h %h %d %d", a, b, c, d, e, f, n);
        i_checker.add_record(a[15:0], b[15:0], c[15:0], d[15:0], e, f != 0, n);
        for (i = 0; i < n; i++) begin
          rc = $fscanf(fh, " %h", a);
          i_checker.add_byte(a[7:0]);
        end
      end else if (tok == "C") begin
        rc = $fscanf(fh, " %d %d", f, g);
        exp_rx   = len_t'(f);
        exp_drop = len_t'(g);
      end else begin
        $display("Unknown record %0s in the stimulus file", tok);
        stim_errs++;
      end
      rc = $fscanf(fh, " %s", tok);
    end
  endtask

  task automatic idle_inputs();
    in_val = 1'b0;
    in_sof = 1'b0;
    in_eof = 1'b0;
    in_err = 1'b0;
  endtask

  task automatic send_packet(input int idx, input int first);
    int i;
    int g;
    for (i = 0; i < pkt_n[idx]; i++) begin
      @(posedge clk);
      #2;
      in_dat     = pkt_bytes[first + i];
      in_val     = 1'b1;
      in_sof     = (i == 0);
      in_eof     = (i == pkt_n[idx] - 1);
      in_err     = pkt_err[idx] && in_eof;
      in_proto   = pkt_proto[idx];       // Metadata held until the next packet
      in_src_ip  = pkt_ip[idx];
      in_pld_len = pkt_len[idx];
      for (g = 0; g < pkt_gap[idx] && i != pkt_n[idx] - 1; g++) begin
        @(posedge clk);
        #2;
        idle_inputs();
      end
    end
  endtask

  initial begin
    cycle_cnt = 0;
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with the run not finished", cycle_limit);
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt + stim_errs);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    fsm_rst     = 1'b1;
    in_dat      = '0;
    idle_inputs();
    in_proto    = '0;
    in_src_ip   = '0;
    in_dst_ip   = 32'h0a00_0001;
    in_pld_len  = '0;
    exp_rx      = '0;
    exp_drop    = '0;
    stim_errs   = 0;
    cycle_limit = 0;
    fd = $fopen("udp_rx_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file udp_rx_stim.txt");
      $display("Testbench failed");
      $finish;
    end else begin
      read_stim(fd);
      $fclose(fd);
      cycle_limit = 25;   // Reset and drain
      for (p = 0; p < pkt_n.size(); p++) begin
        cycle_limit += pkt_n[p] + pkt_gap[p] * (pkt_n[p] - 1) + 50;
      end

      repeat (5) @(posedge clk);
      #2;
      fsm_rst = 1'b0;

      base = 0;
      for (p = 0; p < pkt_n.size(); p++) begin
        send_packet(p, base);
        base += pkt_n[p];
      end
      @(posedge clk);
      #2;
      idle_inputs();

      // Wait for the DUT to deliver what is still owed
      waited = 0;
      while (busy && waited < 20) begin
        @(posedge clk);
        waited++;
      end
      repeat (4) @(posedge clk);
      #2;
      i_checker.final_check(exp_rx, exp_drop);

      $display("Checks: %0d, errors: %0d", check_cnt, err_cnt + stim_errs);
      if (err_cnt + stim_errs == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* build.f */
udp_rx_pkg.sv
ipv4_rx_if.sv
udp_rx_if.sv
udp_hdr_rx.sv
udp_port_filter.sv
udp_rx_top.sv
tb_udp_rx_checker.sv
tb_udp_rx.sv

/* Bender.yml */
package:
  name: udp_rx

sources:
  - udp_rx_pkg.sv
  - ipv4_rx_if.sv
  - udp_rx_if.sv
  - udp_hdr_rx.sv
  - udp_port_filter.sv
  - udp_rx_top.sv
  - target: simulation
    files:
      - tb_udp_rx_checker.sv
      - tb_udp_rx.sv

/* udp_rx_stim.txt */
# P lines are packets in, E lines expected datagrams out, C the final counters
# P proto src_ip pld_len in_err gap nbytes bytes   (gap = idle cycles after each byte)
# E src_port dst_port length cks src_ip out_err nbytes payload
# Fields are hex apart from in_err, gap, nbytes and the counters

# Datagram to the local port
P 11 c0a80001 000c 0 0 12 04 00 12 34 00 0c be ef 11 22 33 44
E 0400 1234 000c beef c0a80001 0 4 11 22 33 44

# TCP segment with the same port bytes, no output
P 06 c0a80002 000a 0 0 10 00 50 12 34 00 0a 00 00 aa bb

# Other destination port, dropped
P 11 c0a80003 000b 0 0 11 10 00 56 78 00 0b 12 34 01 02 03

# IPv4 length larger than the bytes sent
P 11 c0a80004 000e 0 0 11 20 00 12 34 00 0e 55 aa a1 a2 a3
E 2000 1234 000e 55aa c0a80004 1 3 a1 a2 a3

# Input err on the last byte
P 11 c0a80005 000a 1 0 10 30 00 12 34 00 0a 00 00 de ad
E 3000 1234 000a 0000 c0a80005 1 2 de ad

# Two idle cycles after every byte
P 11 c0a80006 000d 0 2 13 40 01 12 34 00 0d 12 ab 01 23 45 67 89
E 4001 1234 000d 12ab c0a80006 0 5 01 23 45 67 89

# Dropped, with gaps
P 11 c0a80007 0009 0 1 9 00 35 00 35 00 09 00 00 ff

# ICMP, no output
P 01 c0a80008 0008 0 0 8 08 00 f7 ff 00 01 00 01

# Single payload byte
P 11 c0a80009 0009 0 0 9 a0 00 12 34 00 09 00 00 5a
E a000 1234 0009 0000 c0a80009 0 1 5a

C 5 2
